//--- src/memory_request_pkg.sv
// ------------------------------
// Shared types for the request arbiter and its queues
// Packet payload is 72 bits wide, 73 with the valid strobe
// Command value 2'd3 is reserved and passes the response filter
// ------------------------------

package memory_request_pkg;

  // ------------------------------
  // Command encoding
  // ------------------------------
  typedef enum logic [1:0] {
    CMD_MEM_READ     = 2'd0,
    CMD_MEM_WRITE    = 2'd1,
    CMD_MEM_RESPONSE = 2'd2
  } mem_cmd_e;

  // ------------------------------
  // Packets
  // ------------------------------
  // One memory request, MSB first
  typedef struct packed {
    mem_cmd_e    cmd;
    logic [3:0]  id;
    logic [31:0] address;
    logic [31:0] data;
    logic [1:0]  spare;
  } memory_payload_t;

  // Payload plus its one-cycle strobe
  typedef struct packed {
    logic            valid;
    memory_payload_t payload;
  } memory_packet_t;

  // ------------------------------
  // FIFO control and status
  // ------------------------------
  // Internal FIFO controls
  typedef struct packed {
    logic wr_en;
    logic rd_en;
  } fifo_ctrl_t;

  // Internal FIFO flags
  typedef struct packed {
    logic full;
    logic empty;
    logic valid;
    logic prog_full;
    logic rst_busy;
  } fifo_status_t;

  // Downstream pop level
  typedef struct packed {
    logic rd_en;
  } fifo_port_in_t;

  // Output queue state seen by the downstream port
  typedef struct packed {
    logic empty;
    logic prog_full;
  } fifo_port_out_t;

endpackage : memory_request_pkg

//--- src/sync_fifo.sv
// ------------------------------
// Synchronous FIFO, one clock, registered read data and valid
// Writes while full and reads while empty are dropped
// full and prog_full also read high during the reset busy window
// Busy window is four cycles after reset, no access in that time
// ------------------------------

`timescale 1ns/1ps

module sync_fifo #(
  parameter int DEPTH       = 16,
  parameter int PROG_THRESH = 12
) (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  memory_request_pkg::memory_payload_t din,
  input  memory_request_pkg::fifo_ctrl_t      ctrl,
  output memory_request_pkg::memory_payload_t dout,
  output memory_request_pkg::fifo_status_t    status
);

  import memory_request_pkg::*;

  localparam int PTR_W       = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W       = $clog2(DEPTH + 1);
  localparam int BUSY_CYCLES = 4;
  localparam int BUSY_W      = $clog2(BUSY_CYCLES + 1);

  // ------------------------------
  // Storage and pointers
  // ------------------------------
  memory_payload_t mem [DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [BUSY_W-1:0] busy_cnt;
  logic              rst_busy;
  logic              read_valid;
  logic              wr_ok;
  logic              rd_ok;

  // Busy while the post-reset counter runs
  assign rst_busy = (busy_cnt != '0);

  // Flags from the occupancy count
  assign status = '{
    full:      (count == CNT_W'(DEPTH)) | rst_busy,
    empty:     (count == '0),
    valid:     read_valid,
    prog_full: (count >= CNT_W'(PROG_THRESH)) | rst_busy,
    rst_busy:  rst_busy
  };

  // Accepted accesses only
  assign wr_ok = ctrl.wr_en & ~status.full;
  assign rd_ok = ctrl.rd_en & ~status.empty & ~rst_busy;

  // ------------------------------
  // Control state
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      read_valid <= 1'b0;
      busy_cnt   <= BUSY_W'(BUSY_CYCLES);
    end else begin
      if (rst_busy) begin
        busy_cnt <= busy_cnt - 1'b1;
      end
      // Explicit wrap, any depth works
      if (wr_ok) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Data shows up the cycle after the pop
      read_valid <= rd_ok;
    end
  end

  // ------------------------------
  // Data path
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
    if (rd_ok) begin
      dout <= mem[rd_ptr];
    end
  end

  // Callers must respect the flags
  a_no_write_when_full : assert property (
    @(posedge ap_clk) disable iff (areset_control) ctrl.wr_en |-> !status.full
  );
  a_no_read_when_empty : assert property (
    @(posedge ap_clk) disable iff (areset_control) ctrl.rd_en |-> !status.empty
  );

endmodule : sync_fifo

//--- src/round_robin_bus_arbiter.sv
// ------------------------------
// Round-robin grant with a registered packet mux behind it
// Grant is combinational, one-hot or zero, one per cycle
// Requesters must return at most one valid packet per cycle
// Muxed packet lands on bus_out one cycle after its valid
// ------------------------------

`timescale 1ns/1ps

module round_robin_bus_arbiter #(
  parameter int NUM_REQUESTORS = 2
) (
  input  logic                               ap_clk,
  input  logic                               areset_control,
  input  logic [NUM_REQUESTORS-1:0]          arbiter_req,
  input  logic [NUM_REQUESTORS-1:0]          bus_valid,
  input  memory_request_pkg::memory_packet_t bus_in [NUM_REQUESTORS],
  output logic [NUM_REQUESTORS-1:0]          arbiter_grant,
  output memory_request_pkg::memory_packet_t bus_out
);

  import memory_request_pkg::*;

  localparam int IDX_W = (NUM_REQUESTORS > 1) ? $clog2(NUM_REQUESTORS) : 1;

  logic [IDX_W-1:0] last_idx;
  logic [IDX_W-1:0] grant_idx;
  logic             grant_found;
  memory_payload_t  bus_sel;

  // ------------------------------
  // Rotating priority
  // ------------------------------
  // Search starts just past the last winner
  always_comb begin
    int idx;
    arbiter_grant = '0;
    grant_idx     = last_idx;
    grant_found   = 1'b0;
    for (int k = 1; k <= NUM_REQUESTORS; k++) begin
      idx = (int'(last_idx) + k) % NUM_REQUESTORS;
      if (!grant_found && arbiter_req[idx]) begin
        arbiter_grant[idx] = 1'b1;
        grant_idx          = IDX_W'(idx);
        grant_found        = 1'b1;
      end
    end
  end

  // Pointer moves only on a grant
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      // First grant after reset goes to index 0
      last_idx <= IDX_W'(NUM_REQUESTORS - 1);
    end else if (grant_found) begin
      last_idx <= grant_idx;
    end
  end

  // ------------------------------
  // Packet mux
  // ------------------------------
  // Select by returned valid, not by grant
  always_comb begin
    bus_sel = '0;
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      if (bus_valid[i]) begin
        bus_sel = bus_in[i].payload;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      bus_out.valid <= 1'b0;
    end else begin
      bus_out.valid <= |bus_valid;
    end
    bus_out.payload <= bus_sel;
  end

  a_grant_onehot : assert property (
    @(posedge ap_clk) disable iff (areset_control) $onehot0(arbiter_grant)
  );
  // Holds only if queues pop on grant alone
  a_bus_valid_onehot : assert property (
    @(posedge ap_clk) disable iff (areset_control) $onehot0(bus_valid)
  );

endmodule : round_robin_bus_arbiter

//--- src/request_arbiter_n_to_1.sv
// ------------------------------
// N requesters into one memory port, round-robin, one packet per cycle
// Requesters must stop within two cycles of their grant_out bit dropping
// Response commands are dropped before the output queue
// All outputs are registered, setup stays high while any queue is busy
// ------------------------------

`timescale 1ns/1ps

module request_arbiter_n_to_1 #(
  parameter int NUM_REQUESTORS  = 2,
  parameter int IN_FIFO_DEPTH   = 16,
  parameter int IN_PROG_THRESH  = 12,
  parameter int OUT_FIFO_DEPTH  = 64,
  parameter int OUT_PROG_THRESH = 16
) (
  input  logic                               ap_clk,
  input  logic                               areset_control,
  input  memory_request_pkg::memory_packet_t request_in [NUM_REQUESTORS],
  input  memory_request_pkg::fifo_port_in_t  fifo_request_signals_in,
  output memory_request_pkg::fifo_port_out_t fifo_request_signals_out,
  output logic [NUM_REQUESTORS-1:0]          grant_out,
  output memory_request_pkg::memory_packet_t request_out,
  output logic                               fifo_setup_signal
);

  import memory_request_pkg::*;

  // ------------------------------
  // Signals
  // ------------------------------
  // Local reset copies
  logic areset_top;
  logic areset_fifo;
  logic areset_arbiter;

  // Input stage
  memory_packet_t request_in_reg [NUM_REQUESTORS];
  fifo_port_in_t  fifo_request_signals_in_reg;

  // Per-requester queues
  memory_payload_t in_dout   [NUM_REQUESTORS];
  fifo_ctrl_t      in_ctrl   [NUM_REQUESTORS];
  fifo_status_t    in_status [NUM_REQUESTORS];

  logic [NUM_REQUESTORS-1:0] in_busy;
  logic [NUM_REQUESTORS-1:0] in_prog_full;

  // Arbiter side
  logic [NUM_REQUESTORS-1:0] arb_req;
  logic [NUM_REQUESTORS-1:0] arb_grant;
  logic [NUM_REQUESTORS-1:0] arb_bus_valid;
  memory_packet_t            arb_bus_in [NUM_REQUESTORS];
  memory_packet_t            arb_bus_out;

  // Filter and output queue
  memory_packet_t  filter_reg;
  logic            filter_pass;
  memory_payload_t out_dout;
  fifo_ctrl_t      out_ctrl;
  fifo_status_t    out_status;

  // ------------------------------
  // Reset copies
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    areset_top     <= areset_control;
    areset_fifo    <= areset_control;
    areset_arbiter <= areset_control;
  end

  // ------------------------------
  // Input registers
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_top) begin
      fifo_request_signals_in_reg <= '0;
      for (int i = 0; i < NUM_REQUESTORS; i++) begin
        request_in_reg[i].valid <= 1'b0;
      end
    end else begin
      fifo_request_signals_in_reg <= fifo_request_signals_in;
      for (int i = 0; i < NUM_REQUESTORS; i++) begin
        request_in_reg[i].valid <= request_in[i].valid;
      end
    end
    // Payload is not reset
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      request_in_reg[i].payload <= request_in[i].payload;
    end
  end

  // ------------------------------
  // Per-requester queues
  // ------------------------------
  for (genvar i = 0; i < NUM_REQUESTORS; i++) begin : g_in_queue
    // Push on registered valid, pop on grant
    assign in_ctrl[i] = '{
      wr_en: request_in_reg[i].valid,
      rd_en: arb_grant[i] & ~in_status[i].empty
    };

    // Arbiter wants any non-empty queue
    assign arb_req[i]       = ~in_status[i].empty;
    assign arb_bus_valid[i] = in_status[i].valid;
    assign arb_bus_in[i]    = '{valid: in_status[i].valid, payload: in_dout[i]};

    assign in_busy[i]      = in_status[i].rst_busy;
    assign in_prog_full[i] = in_status[i].prog_full;

    sync_fifo #(
      .DEPTH      (IN_FIFO_DEPTH),
      .PROG_THRESH(IN_PROG_THRESH)
    ) u_in_fifo (
      .ap_clk        (ap_clk),
      .areset_control(areset_fifo),
      .din           (request_in_reg[i].payload),
      .ctrl          (in_ctrl[i]),
      .dout          (in_dout[i]),
      .status        (in_status[i])
    );
  end

  round_robin_bus_arbiter #(
    .NUM_REQUESTORS(NUM_REQUESTORS)
  ) u_arbiter (
    .ap_clk        (ap_clk),
    .areset_control(areset_arbiter),
    .arbiter_req   (arb_req),
    .bus_valid     (arb_bus_valid),
    .bus_in        (arb_bus_in),
    .arbiter_grant (arb_grant),
    .bus_out       (arb_bus_out)
  );

  // ------------------------------
  // Response filter
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_top) begin
      filter_reg.valid <= 1'b0;
    end else begin
      filter_reg.valid <= arb_bus_out.valid;
    end
    filter_reg.payload <= arb_bus_out.payload;
  end

  // Responses never reach the memory port
  assign filter_pass = (filter_reg.payload.cmd != CMD_MEM_RESPONSE);

  // ------------------------------
  // Output queue
  // ------------------------------
  assign out_ctrl = '{
    wr_en: filter_reg.valid & filter_pass,
    rd_en: fifo_request_signals_in_reg.rd_en & ~out_status.empty
  };

  sync_fifo #(
    .DEPTH      (OUT_FIFO_DEPTH),
    .PROG_THRESH(OUT_PROG_THRESH)
  ) u_out_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_fifo),
    .din           (filter_reg.payload),
    .ctrl          (out_ctrl),
    .dout          (out_dout),
    .status        (out_status)
  );

  // ------------------------------
  // Output registers
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_top) begin
      request_out.valid        <= 1'b0;
      fifo_request_signals_out <= '0;
      fifo_setup_signal        <= 1'b1;
      grant_out                <= '0;
    end else begin
      request_out.valid                  <= out_status.valid;
      fifo_request_signals_out.empty     <= out_status.empty;
      fifo_request_signals_out.prog_full <= out_status.prog_full;
      // Setup until every queue leaves its busy window
      fifo_setup_signal <= out_status.rst_busy | (|in_busy);
      // Own queue or shared queue nearly full stops a requester
      grant_out <= ~(in_prog_full | {NUM_REQUESTORS{out_status.prog_full}});
    end
    request_out.payload <= out_dout;
  end

  // Filter and output queue together keep responses off the port
  a_no_response_out : assert property (
    @(posedge ap_clk) disable iff (areset_top)
      request_out.valid |-> request_out.payload.cmd != CMD_MEM_RESPONSE
  );

endmodule : request_arbiter_n_to_1

//--- tests/request_arbiter_tasks.svh
// ------------------------------
// Testbench tasks, included in the testbench module body
// Uses the module's DUT signals, the received queue and the LFSR state
// Every wait loop ends the run on its own timeout
// ------------------------------

`ifndef REQUEST_ARBITER_TASKS_SVH
`define REQUEST_ARBITER_TASKS_SVH

// ------------------------------
// Random data
// ------------------------------
// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic lfsr_next_bit();
  logic feedback;
  feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
  lfsr_state = {lfsr_state[14:0], feedback};
  return feedback;
endfunction

// One LFSR step per bit
function automatic logic [31:0] random_word();
  logic [31:0] word;
  word = '0;
  for (int b = 0; b < 32; b++) begin
    word = {word[30:0], lfsr_next_bit()};
  end
  return word;
endfunction

function automatic memory_payload_t make_payload(input mem_cmd_e cmd, input logic [3:0] id);
  memory_payload_t p;
  p.cmd     = cmd;
  p.id      = id;
  p.address = random_word();
  p.data    = random_word();
  p.spare   = 2'b00;
  return p;
endfunction

// ------------------------------
// Checks and waits
// ------------------------------
task automatic fail_run(input string reason);
  $display("%s", reason);
  $display("TESTS FAILED");
  $fatal(1);
endtask

task automatic check_value(input string name, input logic [127:0] actual,
                           input logic [127:0] expected);
  if (actual !== expected) begin
    $display("Error: %s got 0x%0h, expected 0x%0h", name, actual, expected);
    fail_run("Value mismatch");
  end
endtask

task automatic wait_setup_done(input int limit);
  int n;
  n = 0;
  while (fifo_setup_signal !== 1'b0) begin
    if (n >= limit) begin
      fail_run("fifo_setup_signal stayed high after reset");
    end
    @(negedge ap_clk);
    n++;
  end
endtask

task automatic wait_grants_high(input int limit);
  int n;
  n = 0;
  while (grant_out !== '1) begin
    if (n >= limit) begin
      fail_run("grant_out did not return high for every requester");
    end
    @(negedge ap_clk);
    n++;
  end
endtask

task automatic wait_for_packets(input int count, input int limit);
  int n;
  n = 0;
  while (received.size() < count) begin
    if (n >= limit) begin
      fail_run("Timed out waiting for packets on request_out");
    end
    @(negedge ap_clk);
    n++;
  end
endtask

// Nothing beyond count may arrive within the window
task automatic wait_quiet(input int count, input int cycles);
  for (int n = 0; n < cycles; n++) begin
    @(negedge ap_clk);
    if (received.size() > count) begin
      fail_run("Unexpected packet appeared on request_out");
    end
  end
endtask

// ------------------------------
// Stimulus helpers
// ------------------------------
task automatic set_read_enable(input logic value);
  @(negedge ap_clk);
  fifo_request_signals_in.rd_en = value;
endtask

// Drive in the current falling edge
task automatic drive_packet(input int r, input memory_payload_t p);
  for (int i = 0; i < NUM_REQUESTORS; i++) begin
    request_in[i].valid = 1'b0;
  end
  request_in[r] = '{valid: 1'b1, payload: p};
endtask

task automatic send_packet(input int r, input memory_payload_t p);
  @(negedge ap_clk);
  drive_packet(r, p);
endtask

task automatic send_pair(input memory_payload_t p0, input memory_payload_t p1);
  @(negedge ap_clk);
  request_in[0] = '{valid: 1'b1, payload: p0};
  request_in[1] = '{valid: 1'b1, payload: p1};
endtask

task automatic drive_idle();
  for (int i = 0; i < NUM_REQUESTORS; i++) begin
    request_in[i].valid = 1'b0;
  end
endtask

task automatic idle_requests();
  @(negedge ap_clk);
  drive_idle();
endtask

// ------------------------------
// Directed tests
// ------------------------------
task automatic test_reset_setup();
  areset_control = 1'b1;
  for (int cyc = 1; cyc <= 8; cyc++) begin
    @(negedge ap_clk);
    // Reset copies take a cycle, outputs settle after that
    if (cyc >= 3) begin
      check_value("request_out.valid", request_out.valid, 1'b0);
      check_value("fifo_setup_signal", fifo_setup_signal, 1'b1);
      check_value("fifo_request_signals_out", fifo_request_signals_out, 2'b00);
    end
  end
  areset_control = 1'b0;
  @(negedge ap_clk);
  check_value("request_out.valid", request_out.valid, 1'b0);
  check_value("fifo_setup_signal", fifo_setup_signal, 1'b1);
  wait_setup_done(50);
  wait_grants_high(50);
endtask

task automatic test_single_order();
  memory_payload_t sent [$];
  memory_payload_t p;
  received.delete();
  set_read_enable(1'b1);
  for (int k = 0; k < 8; k++) begin
    p = make_payload((k % 2 == 1) ? CMD_MEM_WRITE : CMD_MEM_READ, 4'd0);
    sent.push_back(p);
    send_packet(0, p);
  end
  idle_requests();
  wait_for_packets(8, 200);
  wait_quiet(8, 20);
  for (int k = 0; k < 8; k++) begin
    check_value("request_out.payload", received[k], sent[k]);
  end
endtask

task automatic test_response_filter();
  memory_payload_t expected [$];
  memory_payload_t p;
  mem_cmd_e        cmd;
  received.delete();
  set_read_enable(1'b1);
  for (int k = 0; k < 9; k++) begin
    case (k % 3)
      0:       cmd = CMD_MEM_READ;
      1:       cmd = CMD_MEM_RESPONSE;
      default: cmd = CMD_MEM_WRITE;
    endcase
    p = make_payload(cmd, 4'd1);
    // Responses never reach the memory port
    if (cmd != CMD_MEM_RESPONSE) begin
      expected.push_back(p);
    end
    send_packet(1, p);
  end
  idle_requests();
  wait_for_packets(expected.size(), 200);
  wait_quiet(expected.size(), 40);
  for (int k = 0; k < expected.size(); k++) begin
    check_value("request_out.payload", received[k], expected[k]);
  end
endtask

task automatic test_round_robin();
  memory_payload_t sent0 [$];
  memory_payload_t sent1 [$];
  memory_payload_t p0;
  memory_payload_t p1;
  int              idx0;
  int              idx1;
  received.delete();
  idx0 = 0;
  idx1 = 0;
  set_read_enable(1'b0);
  for (int k = 0; k < 4; k++) begin
    p0 = make_payload(CMD_MEM_READ, 4'd0);
    p1 = make_payload(CMD_MEM_WRITE, 4'd1);
    sent0.push_back(p0);
    sent1.push_back(p1);
    send_pair(p0, p1);
  end
  idle_requests();
  // Output port held, so nothing leaves yet
  wait_quiet(0, 20);
  set_read_enable(1'b1);
  wait_for_packets(8, 200);
  wait_quiet(8, 20);
  for (int k = 1; k < 8; k++) begin
    check_value("request_out.payload.id alternates",
                received[k].id != received[k-1].id, 1'b1);
  end
  // Each requester keeps its own order
  for (int k = 0; k < 8; k++) begin
    if (received[k].id == 4'd0) begin
      check_value("request_out.payload", received[k], sent0[idx0]);
      idx0++;
    end else begin
      check_value("request_out.payload", received[k], sent1[idx1]);
      idx1++;
    end
  end
endtask

task automatic test_back_pressure();
  memory_payload_t sent [$];
  memory_payload_t p;
  int              n;
  received.delete();
  n = 0;
  set_read_enable(1'b0);
  @(negedge ap_clk);
  while (grant_out[0] === 1'b1) begin
    if (n >= 60) begin
      fail_run("grant_out[0] never dropped before the output queue could overflow");
    end
    p = make_payload((n % 2 == 1) ? CMD_MEM_WRITE : CMD_MEM_READ, 4'd0);
    sent.push_back(p);
    drive_packet(0, p);
    n++;
    @(negedge ap_clk);
  end
  drive_idle();
  check_value("fifo_request_signals_out.prog_full", fifo_request_signals_out.prog_full, 1'b1);
  check_value("fifo_request_signals_out.empty", fifo_request_signals_out.empty, 1'b0);
  // Shared queue nearly full stops every requester
  check_value("grant_out", grant_out, '0);
  set_read_enable(1'b1);
  wait_for_packets(n, 400);
  wait_quiet(n, 20);
  for (int k = 0; k < n; k++) begin
    check_value("request_out.payload", received[k], sent[k]);
  end
  wait_grants_high(50);
  check_value("fifo_request_signals_out.empty", fifo_request_signals_out.empty, 1'b1);
endtask

`endif

//--- tests/request_arbiter_tb.sv
// ------------------------------
// Directed testbench for the N to 1 request arbiter, two requesters
// Inputs change on the falling edge, outputs sampled on the rising edge
// The first failed check ends the run
// ------------------------------

`timescale 1ns/1ps

module request_arbiter_tb;

  import memory_request_pkg::*;

  localparam int NUM_REQUESTORS  = 2;
  localparam int IN_FIFO_DEPTH   = 16;
  localparam int IN_PROG_THRESH  = 12;
  localparam int OUT_FIFO_DEPTH  = 64;
  localparam int OUT_PROG_THRESH = 16;

  // ------------------------------
  // DUT signals
  // ------------------------------
  logic                      ap_clk;
  logic                      areset_control;
  memory_packet_t            request_in [NUM_REQUESTORS];
  fifo_port_in_t             fifo_request_signals_in;
  fifo_port_out_t            fifo_request_signals_out;
  logic [NUM_REQUESTORS-1:0] grant_out;
  memory_packet_t            request_out;
  logic                      fifo_setup_signal;

  // Packets seen on request_out, oldest first
  memory_payload_t received [$];

  // Random data source
  logic [15:0] lfsr_state;

  `include "request_arbiter_tasks.svh"

  // ------------------------------
  // Clock, 4 ns period
  // ------------------------------
  initial begin
    ap_clk = 1'b0;
  end

  always #2 ap_clk = ~ap_clk;

  // ------------------------------
  // DUT
  // ------------------------------
  request_arbiter_n_to_1 #(
    .NUM_REQUESTORS (NUM_REQUESTORS),
    .IN_FIFO_DEPTH  (IN_FIFO_DEPTH),
    .IN_PROG_THRESH (IN_PROG_THRESH),
    .OUT_FIFO_DEPTH (OUT_FIFO_DEPTH),
    .OUT_PROG_THRESH(OUT_PROG_THRESH)
  ) UUT (
    .ap_clk                  (ap_clk),
    .areset_control          (areset_control),
    .request_in              (request_in),
    .fifo_request_signals_in (fifo_request_signals_in),
    .fifo_request_signals_out(fifo_request_signals_out),
    .grant_out               (grant_out),
    .request_out             (request_out),
    .fifo_setup_signal       (fifo_setup_signal)
  );

  // ------------------------------
  // Output monitor
  // ------------------------------
  // Pre-edge value, held for the whole previous cycle
  always @(posedge ap_clk) begin
    if (request_out.valid === 1'b1) begin
      received.push_back(request_out.payload);
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    lfsr_state              = 16'd31;
    areset_control          = 1'b1;
    fifo_request_signals_in = '0;
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      request_in[i] = '0;
    end

    test_reset_setup();
    $display("Reset and setup done");
    test_single_order();
    $display("Single requester order done");
    test_response_filter();
    $display("Response filtering done");
    test_round_robin();
    $display("Round-robin fairness done");
    test_back_pressure();
    $display("Back-pressure done");

    $display("TESTS PASSED");
    $finish;
  end

endmodule : request_arbiter_tb

//--- project.f
+incdir+tests
src/memory_request_pkg.sv
src/sync_fifo.sv
src/round_robin_bus_arbiter.sv
src/request_arbiter_n_to_1.sv
tests/request_arbiter_tb.sv

//--- Makefile
# Verilator build and run for the request arbiter testbench

TOP := request_arbiter_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
